/* Bender.yml */
package:
  name: return_predictor

sources:
  - include_dirs:
      - design
    files:
      - design/RetPkg.sv
      - design/RecoveryIf.sv
      - design/RetLocTable.sv
      - design/RetRecoveryQueue.sv
      - design/ReturnStack.sv
      - design/ReturnPredictor.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/ReturnPredictor_props.sv
      - bench/ReturnPredictorTb.sv

/* bench/ReturnPredictorTb.sv */
`timescale 1ns/1ns

module ReturnPredictorTb import RetPkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 16;
    localparam int CYCLES_PER_TEST = 40;
    localparam int MAX_TESTS = 64;
    localparam int NUM_FIELDS = 14;

    // opcodes in the first column of a test line
    localparam int OP_FETCH = 1;
    localparam int OP_COMMIT = 2;
    localparam int OP_MISPR = 3;
    localparam int OP_UPDATE = 4;
    localparam int OP_WAIT = 5;

    logic clk;
    logic rst;
    logic fetchValid;
    FetchID_t fetchId;
    logic [30:0] fetchPc;
    logic [30:0] lastPc;
    logic brValid;
    logic brIsCall;
    logic brIsRet;
    FetchOff_t brOffs;
    logic [30:0] brDst;
    FetchID_t comFetchId;
    logic mispr;
    RetStackIdx_t misprIdx;
    FetchID_t misprFetchId;
    logic updValid;
    logic updIsCall;
    logic updIsRet;
    logic updCleanRet;
    logic updCompr;
    RetStackIdx_t updIdx;
    logic [30:0] updAddr;

    logic stall;
    logic [30:0] curRetAddr;
    RetStackIdx_t curIdx;
    logic predValid;
    FetchOff_t predOffs;
    logic predCompr;

    logic [31:0] tests [MAX_TESTS][NUM_FIELDS];
    int numTests;
    logic loaded;
    int valueErrors;
    int otherErrors;

    // expected outputs of the line consumed at the last rising edge
    logic [31:0] expVals [NUM_FIELDS];
    logic havePending;

    ReturnPredictor DUT (.*);

    bind ReturnPredictor ReturnPredictorProps props (
        .clk(clk),
        .rst(rst),
        .fetchValid(fetchValid),
        .mispr(mispr),
        .stall(stall),
        .predValid(predValid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic loadTests();
        int fd;
        int n;
        string line;
        logic [31:0] fld [NUM_FIELDS];
        fd = $fopen("bench/ret_tests.txt", "r");
        if (fd == 0) begin
            otherErrors++;
            $display("could not open the test file bench/ret_tests.txt");
        end else begin
            while (!$feof(fd) && numTests < MAX_TESTS) begin
                line = "";
                n = $fgets(line, fd);
                // skip blank lines and comments
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                                fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13]);
                    if (n == NUM_FIELDS) begin
                        tests[numTests] = fld;
                        numTests++;
                    end else begin
                        otherErrors++;
                        $display("malformed test line: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic clearStrobes();
        fetchValid <= 1'b0;
        brValid <= 1'b0;
        brIsCall <= 1'b0;
        brIsRet <= 1'b0;
        mispr <= 1'b0;
        updValid <= 1'b0;
        updIsCall <= 1'b0;
        updIsRet <= 1'b0;
        updCleanRet <= 1'b0;
    endtask

    // levels such as comFetchId and misprIdx hold until a line changes them
    task automatic applyTest(int t);
        clearStrobes();
        case (tests[t][0])
            OP_FETCH: begin
                fetchValid <= 1'b1;
                fetchId <= FetchID_t'(tests[t][1]);
                fetchPc <= tests[t][2][30:0];
                lastPc <= tests[t][3][30:0];
                brValid <= (tests[t][4] != 0);
                brIsCall <= (tests[t][4] == 1);
                brIsRet <= (tests[t][4] == 2);
                brOffs <= FetchOff_t'(tests[t][5]);
                brDst <= tests[t][6][30:0];
            end
            OP_COMMIT: comFetchId <= FetchID_t'(tests[t][1]);
            OP_MISPR: begin
                mispr <= 1'b1;
                misprIdx <= RetStackIdx_t'(tests[t][1]);
                misprFetchId <= FetchID_t'(tests[t][2]);
            end
            OP_UPDATE: begin
                updValid <= 1'b1;
                updIsCall <= (tests[t][1] == 1);
                updIsRet <= (tests[t][1] != 1);
                updCleanRet <= (tests[t][1] == 3);
                updCompr <= tests[t][2][0];
                updIdx <= RetStackIdx_t'(tests[t][3]);
                updAddr <= tests[t][4][30:0];
            end
            default: ;
        endcase
    endtask

    task automatic checkValue(string name, logic [31:0] expected, logic [31:0] observed);
        assert (observed === expected) else begin
            valueErrors++;
            $display("Fail at %0t ns: %s expected %h observed %h", $time, name, expected,
                     observed);
        end
    endtask

    task automatic checkPending();
        logic [31:0] mask;
        mask = expVals[7];
        if (mask[0])
            checkValue("stall", expVals[8], stall);
        if (mask[1])
            checkValue("curRetAddr", expVals[9], curRetAddr);
        if (mask[2])
            checkValue("curIdx", expVals[10], curIdx);
        if (mask[3])
            checkValue("predValid", expVals[11], predValid);
        if (mask[4])
            checkValue("predOffs", expVals[12], predOffs);
        if (mask[5])
            checkValue("predCompr", expVals[13], predCompr);
    endtask

    task automatic printCounts();
        $display("Errors: %0d value mismatches, %0d other failures, %0d property failures",
                 valueErrors, otherErrors, DUT.props.failures);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        fetchValid = 1'b0;
        fetchId = '0;
        fetchPc = '0;
        lastPc = '0;
        brValid = 1'b0;
        brIsCall = 1'b0;
        brIsRet = 1'b0;
        brOffs = '0;
        brDst = '0;
        comFetchId = '0;
        mispr = 1'b0;
        misprIdx = '0;
        misprFetchId = '0;
        updValid = 1'b0;
        updIsCall = 1'b0;
        updIsRet = 1'b0;
        updCleanRet = 1'b0;
        updCompr = 1'b0;
        updIdx = '0;
        updAddr = '0;
        numTests = 0;
        valueErrors = 0;
        otherErrors = 0;
        havePending = 1'b0;
        loaded = 1'b0;
        loadTests();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int t = 0; t < numTests; t++) begin
            @(posedge clk);
            applyTest(t);
            @(negedge clk);
            if (havePending) begin
                checkPending();
            end
            expVals = tests[t];
            havePending = (tests[t][0] != OP_WAIT);
            // recovery length depends on the queue, so follow stall
            if (!havePending) begin
                while (stall !== 1'b0) begin
                    @(negedge clk);
                end
            end
        end
        @(posedge clk);
        clearStrobes();
        @(negedge clk);
        if (havePending) begin
            checkPending();
        end
        printCounts();
        if (valueErrors + otherErrors + DUT.props.failures == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int limitNs;
        wait (loaded === 1'b1);
        limitNs = (numTests * CYCLES_PER_TEST + RESET_CYCLES) * CLK_PERIOD;
        #(limitNs);
        otherErrors++;
        $display("timeout, the tests were still running after %0d ns", limitNs);
        printCounts();
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* bench/ReturnPredictor_props.sv */
`timescale 1ns/1ns

module ReturnPredictorProps (
    input logic clk,
    input logic rst,
    input logic fetchValid,
    input logic mispr,
    input logic stall,
    input logic predValid
);
    // failed assertions, summed up by the testbench
    int failures = 0;

    // the first reset edge clears stall and it stays low through reset
    stallLowInReset: assert property (@(posedge clk) $past(rst) |-> !stall)
        else begin
            failures++;
            $error("stall high while reset is applied");
        end

    stallAfterMispr: assert property (@(posedge clk) disable iff (rst) mispr |=> stall)
        else begin
            failures++;
            $error("stall did not rise one cycle after mispr");
        end

    stallRiseCause: assert property (@(posedge clk) disable iff (rst)
            $rose(stall) |-> $past(mispr))
        else begin
            failures++;
            $error("stall rose without a mispr in the cycle before");
        end

    // the table hit is only registered for a valid fetch
    predNeedsFetch: assert property (@(posedge clk) disable iff (rst)
            !fetchValid |=> !predValid)
        else begin
            failures++;
            $error("predValid high after a cycle without fetchValid");
        end

    noFetchInStall: assert property (@(posedge clk) disable iff (rst) stall |-> !fetchValid)
        else begin
            failures++;
            $error("fetchValid arrived while stall was high");
        end

endmodule

/* bench/ret_tests.txt */
# columns, all hex: op f1 f2 f3 f4 f5 f6 mask stall retAddr idx pred offs compr
# op 0 idle, 1 fetch id pc lastPc br(1 call 2 ret) offs dst, 2 commit id, 3 mispr idx id
# op 4 update kind(1 call 2 ret 3 clean) compr idx addr, 5 wait for stall low; mask bit 0 = stall
# nested calls, returns come back in reverse order
1 01 0100 0000 0 0 0000 0d 0 0000 0 0 0 0
1 02 0200 0100 1 1 0200 0f 0 0102 1 0 0 0
1 03 0300 0200 1 3 0300 0f 0 0204 2 0 0 0
1 04 0400 0300 1 2 0400 0f 0 0303 3 0 0 0
1 05 0500 0400 2 0 0303 0f 0 0204 2 0 0 0
1 06 0303 0500 2 0 0204 0f 0 0102 1 0 0 0
1 07 0700 0303 1 1 0700 0f 0 0302 2 0 0 0
# mispredict at fetch 04 restores both pops
3 3 04 0 0 0 0000 01 1 0000 0 0 0 0
5 0 00 0 0 0 0000 00 0 0000 0 0 0 0
1 08 0800 0000 0 0 0000 0f 0 0303 3 0 0 0
1 09 0900 0800 2 0 0303 0f 0 0204 2 0 0 0
# pops committed before the mispredict stay popped
1 0a 0a00 0900 2 0 0204 0f 0 0102 1 0 0 0
1 0b 0b00 0a00 1 2 0b00 0f 0 0a03 2 0 0 0
2 0b 00 0 0 0 0000 01 0 0000 0 0 0 0
0 00 00 0 0 0 0000 01 0 0000 0 0 0 0
3 2 0b 0 0 0 0000 01 1 0000 0 0 0 0
5 0 00 0 0 0 0000 00 0 0000 0 0 0 0
1 0c 0c00 0000 0 0 0000 0f 0 0a03 2 0 0 0
# decode call fix at index 1
4 1 0 1 1234 0 0000 01 0 0000 0 0 0 0
1 0d 0d00 0c00 0 0 0000 0f 0 1235 2 0 0 0
# table training, then a clean return removes the entry
4 2 1 0 4446 0 0000 01 0 0000 0 0 0 0
1 0e 4444 0d00 0 0 0000 3f 0 1235 2 1 2 1
1 0f 4447 4444 0 0 0000 09 0 0000 0 0 0 0
4 3 0 0 4445 0 0000 01 0 0000 0 0 0 0
1 10 4444 4447 0 0 0000 09 0 0000 0 0 0 0

/* design/RecoveryIf.sv */
`timescale 1ns/1ns

interface RecoveryIf import RetPkg::*; ();

    // entry popped by a fetch return, saved for a later rollback
    logic push;
    RetRecEntry pushEntry;

    // mispredict strobe and the fetch id it rolls back to
    logic misprStart;
    FetchID_t misprId;

    // entry written back into the stack in the same cycle
    logic restore;
    RetRecEntry restoreEntry;

    // high while the queue is walking back after a mispredict
    logic recovering;

    modport stack (
        output push, pushEntry, misprStart, misprId,
        input restore, restoreEntry, recovering
    );

    modport queue (
        input push, pushEntry, misprStart, misprId,
        output restore, restoreEntry, recovering
    );

endinterface

/* design/RetLocTable.sv */
`timescale 1ns/1ns
`include "ret_consts.svh"

module RetLocTable import RetPkg::*; (
    input logic clk,
    input logic rst,
    input logic lookupValid,
    input logic [30:0] lookupPc,
    input logic touch,
    input logic updValid,
    input logic [30:0] updAddr,
    input logic updIsRet,
    input logic updCleanRet,
    input logic updCompr,
    output logic hit,
    output FetchOff_t hitOffs,
    output logic hitCompr
);
    localparam int SETS = `RET_PRED_SIZE / `RET_PRED_ASSOC;
    localparam int WAYS = `RET_PRED_ASSOC;
    localparam int SET_W = $clog2(SETS);
    localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1;
    localparam int TAG_W = `RET_PRED_TAG_LEN;
    localparam int SHIFT = `FETCH_OFF_W;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        // offset of the second halfword for a 32 bit return, else the first
        FetchOff_t offs;
        logic compr;
        logic used;
        logic valid;
    } LocEntry_t;

    LocEntry_t locTable [SETS][WAYS];

    logic [SET_W-1:0] lookupSet;
    logic [TAG_W-1:0] lookupTag;
    logic [SET_W-1:0] updSet;
    logic [TAG_W-1:0] updTag;
    logic anyHit;
    logic [WAY_W-1:0] matchWay;
    logic insOk;
    logic [WAY_W-1:0] insWay;

    // set and way behind the registered hit
    logic [SET_W-1:0] hitSet;
    logic [WAY_W-1:0] hitWay;

    // index and tag are xor folds of the block address
    function automatic logic [SET_W-1:0] setOf(logic [30:0] pc);
        return pc[SHIFT +: SET_W] ^ pc[SHIFT + SET_W +: SET_W];
    endfunction

    function automatic logic [TAG_W-1:0] tagOf(logic [30:0] pc);
        return pc[SHIFT +: TAG_W] ^ pc[SHIFT + TAG_W +: TAG_W];
    endfunction

    always_comb begin
        lookupSet = setOf(lookupPc);
        lookupTag = tagOf(lookupPc);
        updSet = setOf(updAddr);
        updTag = tagOf(updAddr);

        // the return must not lie before the fetch entry point
        anyHit = 1'b0;
        matchWay = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (locTable[lookupSet][w].valid && locTable[lookupSet][w].tag == lookupTag &&
                    locTable[lookupSet][w].offs >= lookupPc[SHIFT-1:0]) begin
                anyHit = 1'b1;
                matchWay = w[WAY_W-1:0];
            end
        end

        // victim is any unused or invalid way
        insOk = 1'b0;
        insWay = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (!locTable[updSet][w].used || !locTable[updSet][w].valid) begin
                insOk = 1'b1;
                insWay = w[WAY_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hit <= 1'b0;
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    locTable[s][w].valid <= 1'b0;
                    locTable[s][w].used <= 1'b0;
                end
            end
        end else begin
            hit <= lookupValid && anyHit;

            // fetch actually took the predicted return
            if (touch && hit) begin
                locTable[hitSet][hitWay].used <= 1'b1;
            end

            if (updValid) begin
                if (updCleanRet) begin
                    for (int w = 0; w < WAYS; w++) begin
                        if (locTable[updSet][w].tag == updTag) begin
                            locTable[updSet][w].valid <= 1'b0;
                        end
                    end
                end else if (updIsRet) begin
                    if (insOk) begin
                        locTable[updSet][insWay] <= '{tag: updTag, offs: updAddr[SHIFT-1:0],
                                                      compr: updCompr, used: 1'b1,
                                                      valid: 1'b1};
                    end else begin
                        // all ways busy, age them so the next miss can insert
                        for (int w = 0; w < WAYS; w++) begin
                            locTable[updSet][w].used <= 1'b0;
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookupValid) begin
            hitOffs <= locTable[lookupSet][matchWay].offs;
            hitCompr <= locTable[lookupSet][matchWay].compr;
            hitSet <= lookupSet;
            hitWay <= matchWay;
        end
    end

endmodule

/* design/RetPkg.sv */
`include "ret_consts.svh"

package RetPkg;

    // wrapping fetch block id, only ordered relative to some base
    typedef logic [`FETCH_ID_W-1:0] FetchID_t;

    typedef logic [$clog2(`RET_SIZE)-1:0] RetStackIdx_t;

    // slot in the recovery queue
    typedef logic [$clog2(`RET_RQ_SIZE)-1:0] RetRqIdx_t;

    // halfword position inside a fetch block
    typedef logic [`FETCH_OFF_W-1:0] FetchOff_t;

    // one popped stack entry, with the index it came from
    typedef struct packed {
        logic [30:0] addr;
        RetStackIdx_t idx;
        FetchID_t fetchId;
    } RetRecEntry;

    // fetch ids carry no extra wrap bit, so both sides are
    // measured as a distance from a common older base
    function automatic logic idBefore(FetchID_t id, FetchID_t lim, FetchID_t base);
        FetchID_t idOff;
        FetchID_t limOff;
        idOff = id - base;
        limOff = lim - base;
        return idOff < limOff;
    endfunction

endpackage

/* design/RetRecoveryQueue.sv */
`timescale 1ns/1ns
`include "ret_consts.svh"

module RetRecoveryQueue import RetPkg::*; (
    input logic clk,
    input logic rst,
    input FetchID_t comFetchId,
    RecoveryIf.queue rec
);
    localparam int DEPTH = `RET_RQ_SIZE;

    RetRecEntry entries [DEPTH];

    // head is the next free slot, the oldest entry sits count slots below it
    RetRqIdx_t head;
    logic [$clog2(DEPTH):0] count;
    RetRqIdx_t tail;
    RetRqIdx_t newest;
    logic empty;
    logic full;

    // last retired fetch id, the base for wrap-safe ordering
    FetchID_t lastCom;
    FetchID_t recId;
    FetchID_t recBase;

    logic commitStep;
    logic retire;

    always_comb begin
        tail = head - RetRqIdx_t'(count);
        newest = head - 1'b1;
        empty = (count == '0);
        full = (count == DEPTH);

        // commit only moves while fetch is running normally
        commitStep = !rec.recovering && !rec.misprStart && !rec.push &&
                     (comFetchId != lastCom);
        retire = commitStep && !empty && idBefore(entries[tail].fetchId, comFetchId, lastCom);

        // undo pops at or after the mispredicted fetch id, newest first
        rec.restore = rec.recovering && !rec.misprStart && !empty &&
                      !idBefore(entries[newest].fetchId, recId, recBase);
        rec.restoreEntry = entries[newest];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            count <= '0;
            lastCom <= '0;
            rec.recovering <= 1'b0;
        end else begin
            if (rec.misprStart) begin
                rec.recovering <= 1'b1;
            end else if (rec.recovering && !rec.restore) begin
                // queue drained or first older entry reached
                rec.recovering <= 1'b0;
            end

            if (rec.restore) begin
                head <= newest;
                count <= count - 1'b1;
            end else if (rec.push) begin
                head <= head + 1'b1;
                // when full the oldest slot is simply overwritten
                if (!full) begin
                    count <= count + 1'b1;
                end
            end else if (retire) begin
                count <= count - 1'b1;
            end

            // nothing older than comFetchId left, jump the base forward
            if (commitStep) begin
                lastCom <= retire ? entries[tail].fetchId : comFetchId;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rec.misprStart) begin
            recId <= rec.misprId;
            recBase <= lastCom;
        end
        if (rec.push) begin
            entries[head] <= rec.pushEntry;
        end
    end

endmodule

/* design/ReturnPredictor.sv */
`timescale 1ns/1ns

module ReturnPredictor import RetPkg::*; (
    input logic clk,
    input logic rst,

    // fetch
    input logic fetchValid,
    input FetchID_t fetchId,
    input logic [30:0] fetchPc,
    input logic [30:0] lastPc,
    input logic brValid,
    input logic brIsCall,
    input logic brIsRet,
    input FetchOff_t brOffs,
    input logic [30:0] brDst,

    // commit and mispredict
    input FetchID_t comFetchId,
    input logic mispr,
    input RetStackIdx_t misprIdx,
    input FetchID_t misprFetchId,

    // decode updates
    input logic updValid,
    input logic updIsCall,
    input logic updIsRet,
    input logic updCleanRet,
    input logic updCompr,
    input RetStackIdx_t updIdx,
    input logic [30:0] updAddr,

    output logic stall,
    output logic [30:0] curRetAddr,
    output RetStackIdx_t curIdx,
    output logic predValid,
    output FetchOff_t predOffs,
    output logic predCompr
);
    logic touch;

    RecoveryIf recIf ();

    ReturnStack retStack (
        .clk(clk),
        .rst(rst),
        .fetchValid(fetchValid),
        .fetchId(fetchId),
        .lastPc(lastPc),
        .brValid(brValid),
        .brIsCall(brIsCall),
        .brIsRet(brIsRet),
        .brOffs(brOffs),
        .brDst(brDst),
        .mispr(mispr),
        .misprIdx(misprIdx),
        .misprFetchId(misprFetchId),
        .updValid(updValid),
        .updIsCall(updIsCall),
        .updIdx(updIdx),
        .updAddr(updAddr),
        .stall(stall),
        .curRetAddr(curRetAddr),
        .curIdx(curIdx),
        .touch(touch),
        .rec(recIf.stack)
    );

    RetRecoveryQueue recQueue (
        .clk(clk),
        .rst(rst),
        .comFetchId(comFetchId),
        .rec(recIf.queue)
    );

    // table predicts whether the fetch block holds a return
    RetLocTable locTable (
        .clk(clk),
        .rst(rst),
        .lookupValid(fetchValid),
        .lookupPc(fetchPc),
        .touch(touch),
        .updValid(updValid),
        .updAddr(updAddr),
        .updIsRet(updIsRet),
        .updCleanRet(updCleanRet),
        .updCompr(updCompr),
        .hit(predValid),
        .hitOffs(predOffs),
        .hitCompr(predCompr)
    );

endmodule

/* design/ReturnStack.sv */
`timescale 1ns/1ns
`include "ret_consts.svh"

module ReturnStack import RetPkg::*; (
    input logic clk,
    input logic rst,

    // fetch side, the branch belongs to the block fetched last cycle
    input logic fetchValid,
    input FetchID_t fetchId,
    input logic [30:0] lastPc,
    input logic brValid,
    input logic brIsCall,
    input logic brIsRet,
    input FetchOff_t brOffs,
    input logic [30:0] brDst,

    // misprIdx is sampled in the cycle after mispr
    input logic mispr,
    input RetStackIdx_t misprIdx,
    input FetchID_t misprFetchId,

    // decode call fix
    input logic updValid,
    input logic updIsCall,
    input RetStackIdx_t updIdx,
    input logic [30:0] updAddr,

    output logic stall,
    output logic [30:0] curRetAddr,
    output RetStackIdx_t curIdx,
    output logic touch,

    RecoveryIf.stack rec
);
    localparam int DEPTH = `RET_SIZE;

    logic [30:0] stackMem [DEPTH];

    RetStackIdx_t idxReg;
    RetStackIdx_t idx;
    RetStackIdx_t fixIdx;
    logic lastValid;
    logic fwdIdx;
    logic callSeen;
    logic retSeen;
    logic [30:0] pushAddr;

    always_comb begin
        callSeen = lastValid && brValid && brIsCall;
        retSeen = lastValid && brValid && brIsRet && !brIsCall;

        // return lands on the halfword after the call
        pushAddr = {lastPc[30:`FETCH_OFF_W], brOffs} + 31'd1;
        fixIdx = updIdx + 1'b1;

        // old index only arrives a cycle after the mispredict
        idx = idxReg;
        if (fwdIdx) begin
            idx = misprIdx;
        end else if (callSeen) begin
            idx = idxReg + 1'b1;
        end else if (retSeen) begin
            idx = idxReg - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            idxReg <= '0;
            lastValid <= 1'b0;
            fwdIdx <= 1'b0;
        end else begin
            fwdIdx <= mispr;
            lastValid <= fetchValid && !mispr;
            if (!mispr) begin
                idxReg <= idx;
            end
        end
    end

    // call pushes, decode fixes and restores, later ones win
    always_ff @(posedge clk) begin
        if (callSeen && !mispr) begin
            stackMem[idx] <= pushAddr;
        end
        if (updValid && updIsCall) begin
            stackMem[fixIdx] <= updAddr + 31'd1;
        end
        if (rec.restore) begin
            stackMem[rec.restoreEntry.idx] <= rec.restoreEntry.addr;
        end
    end

    always_ff @(posedge clk) begin
        if (fetchValid) begin
            curIdx <= idx;
            // the stack write of a call in this cycle is not visible yet
            curRetAddr <= callSeen ? pushAddr : stackMem[idx];
        end
    end

    // popped entry keeps the index it was read from
    assign rec.push = retSeen && !mispr;
    assign rec.pushEntry = '{addr: brDst, idx: idxReg, fetchId: fetchId};
    assign rec.misprStart = mispr;
    assign rec.misprId = misprFetchId;

    assign touch = rec.push;
    assign stall = rec.recovering;

endmodule

/* design/ret_consts.svh */
`ifndef RET_CONSTS_SVH
`define RET_CONSTS_SVH

// return stack depth
`define RET_SIZE 8

// popped entries kept for mispredict recovery
`define RET_RQ_SIZE 4

// return location table, total entries, ways and tag width
`define RET_PRED_SIZE 16
`define RET_PRED_ASSOC 2
`define RET_PRED_TAG_LEN 8

// fetch block id and halfword offset inside a fetch block
`define FETCH_ID_W 5
`define FETCH_OFF_W 2

`endif

/* sources.f */
+incdir+design
design/RetPkg.sv
design/RecoveryIf.sv
design/RetLocTable.sv
design/RetRecoveryQueue.sv
design/ReturnStack.sv
design/ReturnPredictor.sv
bench/ReturnPredictor_props.sv
bench/ReturnPredictorTb.sv
